// ==== boot_subsystem.f ====
hw/boot_pkg.sv
hw/boot_rom.sv
hw/boot_ctrl.sv
hw/line_fetch.sv
hw/bus_arbiter.sv
hw/biu_wb.sv
hw/wb_sram.sv
hw/boot_subsystem.sv
tests/boot_subsystem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the boot subsystem testbench with Verilator, runs it from the project root
# and decides pass or fail from the simulation log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/10ps --top-module boot_subsystem_tb \
    -f boot_subsystem.f \
    && ./obj_dir/Vboot_subsystem_tb | tee sim.log \
    || { echo "Build or simulation did not complete."; exit 1; }
grep -q "^Verification passed$" sim.log && exit 0 || exit 1

// ==== tests/boot_image.hex ====
// One image line per row, 128 bits, word 0 in the low 32 bits.
B00703FCB00702FDB00701FEB00700FF
B00707F8B00706F9B00705FAB00704FB
B0070BF4B0070AF5B00709F6B00708F7
B0070FF0B0070EF1B0070DF2B0070CF3
B00713ECB00712EDB00711EEB00710EF
B00717E8B00716E9B00715EAB00714EB
B0071BE4B0071AE5B00719E6B00718E7
B0071FE0B0071EE1B0071DE2B0071CE3

// ==== tests/boot_cases.txt ====
1 3 B0070FF0B0070EF1B0070DF2B0070CF3
1 6 B0071BE4B0071AE5B00719E6B00718E7
0 0 B00703FCB00702FDB00701FEB00700FF
0 1 B00707F8B00706F9B00705FAB00704FB
0 2 B0070BF4B0070AF5B00709F6B00708F7
3 3 B0070FF0B0070EF1B0070DF2B0070CF3
0 4 B00713ECB00712EDB00711EEB00710EF
0 5 B00717E8B00716E9B00715EAB00714EB
2 6 B0071BE4B0071AE5B00719E6B00718E7
0 7 B0071FE0B0071EE1B0071DE2B0071CE3
3 0 B00703FCB00702FDB00701FEB00700FF
3 5 B00717E8B00716E9B00715EAB00714EB
2 2 B0070BF4B0070AF5B00709F6B00708F7
0 6 B0071BE4B0071AE5B00719E6B00718E7
3 7 B0071FE0B0071EE1B0071DE2B0071CE3
0 3 B0070FF0B0070EF1B0070DF2B0070CF3

// ==== tests/boot_subsystem_tb.sv ====
// ##########################################################
// Testbench for the boot subsystem. Runs the fetch cases of
// tests/boot_cases.txt (mode, line index, expected line) and
// checks them against the boot image. Run from the project root.
// ##########################################################
`timescale 1ns/10ps
`default_nettype none

module boot_subsystem_tb;

    localparam int BOOT_LIMIT   = 2000; // Cycles.
    localparam int FETCH_LIMIT  = 200;
    localparam int QUIET_CYCLES = 20;

    logic clk;
    logic reset;
    logic fetch_req;
    logic [boot_pkg::ROM_ADDR_WIDTH-1:0] fetch_line_idx;
    logic fetch_busy;
    logic fetch_valid;
    boot_pkg::line_t fetch_line;
    logic boot_done;

    boot_pkg::line_t image_ref [0:boot_pkg::ROM_LINES-1];
    logic boot_seen;
    int fd;
    int mode;
    int idx;
    int case_count;
    boot_pkg::line_t exp_line;

    boot_subsystem u_boot_subsystem (
        .i_wb_clk(clk),
        .i_reset(reset),
        .i_fetch_req(fetch_req),
        .i_fetch_line_idx(fetch_line_idx),
        .o_fetch_busy(fetch_busy),
        .o_fetch_valid(fetch_valid),
        .o_fetch_line(fetch_line),
        .o_boot_done(boot_done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_line(input string what, input boot_pkg::line_t got,
                              input boot_pkg::line_t exp);
        if (got !== exp) begin
            stop_run($sformatf("FAIL at %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("FAIL at %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic wait_boot_done();
        int n;
        n = 0;
        while (boot_done !== 1'b1) begin
            if (n == BOOT_LIMIT) begin
                stop_run("Timed out waiting for o_boot_done to rise.");
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic wait_fetch_valid();
        int n;
        n = 0;
        while (fetch_valid !== 1'b1) begin
            if (n == FETCH_LIMIT) begin
                stop_run("Timed out waiting for o_fetch_valid after a fetch request.");
            end
            @(negedge clk);
            n++;
        end
    endtask

    // Mode 0 fetches after boot, 1 during boot, 2 adds a strobe that must be
    // dropped, 3 launches in the cycle after the previous valid pulse.
    task automatic run_fetch(input int mode, input int idx, input boot_pkg::line_t exp);
        int gap;
        if (mode < 0 || mode > 3 || idx < 0 || idx >= boot_pkg::ROM_LINES) begin
            stop_run("The case file holds an unknown mode or a line index outside the image.");
        end
        check_line("case file line vs image", exp, image_ref[idx]);
        if (mode != 1) begin
            wait_boot_done();
        end
        if (mode == 3) begin
            gap = 1;
        end else if (mode == 1) begin
            gap = 1 + int'($urandom % 3);
        end else begin
            gap = 1 + int'($urandom % 6);
        end
        repeat (gap) @(negedge clk);
        if (mode == 1) begin
            check_flag("o_boot_done at a fetch during boot", boot_done, 1'b0);
        end
        check_flag("o_fetch_busy before launch", fetch_busy, 1'b0);
        fetch_req = 1'b1;
        fetch_line_idx = idx[boot_pkg::ROM_ADDR_WIDTH-1:0];
        @(negedge clk);
        fetch_req = 1'b0;
        if (mode == 2) begin
            check_flag("o_fetch_busy after launch", fetch_busy, 1'b1);
            fetch_req = 1'b1;
            fetch_line_idx = fetch_line_idx ^ 3'd5; // Another line, must be ignored.
            @(negedge clk);
            fetch_req = 1'b0;
        end
        wait_fetch_valid();
        if (mode == 1) begin
            // The host is served between boot lines, not after the last one.
            check_flag("o_boot_done at the valid of a fetch during boot", boot_done, 1'b0);
        end else begin
            check_line($sformatf("o_fetch_line for line %0d", idx), fetch_line, exp);
        end
        if (mode == 2) begin
            repeat (QUIET_CYCLES) begin
                @(negedge clk);
                check_flag("o_fetch_valid after a dropped strobe", fetch_valid, 1'b0);
                check_flag("o_fetch_busy after a dropped strobe", fetch_busy, 1'b0);
            end
        end
    endtask

    // Once boot is seen done it must stay done.
    always @(negedge clk) begin
        if (boot_seen) begin
            check_flag("o_boot_done after boot", boot_done, 1'b1);
        end else if (!reset && boot_done === 1'b1) begin
            boot_seen = 1'b1;
        end
    end

    initial begin
        reset = 1'b1;
        fetch_req = 1'b0;
        fetch_line_idx = '0;
        boot_seen = 1'b0;
        case_count = 0;
        void'($urandom(32'h656c));
        $readmemh("tests/boot_image.hex", image_ref);
        repeat (10) begin
            @(negedge clk);
            check_flag("o_boot_done in reset", boot_done, 1'b0);
            check_flag("o_fetch_valid in reset", fetch_valid, 1'b0);
            check_flag("o_fetch_busy in reset", fetch_busy, 1'b0);
        end
        reset = 1'b0;
        fd = $fopen("tests/boot_cases.txt", "r");
        if (fd == 0) begin
            stop_run("Could not open the case file tests/boot_cases.txt.");
        end
        while ($fscanf(fd, "%d %d %h\n", mode, idx, exp_line) == 3) begin
            run_fetch(mode, idx, exp_line);
            case_count++;
        end
        $fclose(fd);
        wait_boot_done();
        repeat (QUIET_CYCLES) @(negedge clk);
        if (case_count == 0) begin
            stop_run("The case file held no cases.");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== hw/boot_subsystem.sv ====
// ##########################################################
// Top level of the boot subsystem: boot ROM, boot sequencer,
// host fetch port, arbiter, BIU and the Wishbone memory.
// ##########################################################
`timescale 1ns/10ps
`default_nettype none

module boot_subsystem (
    input  wire                                i_wb_clk,
    input  wire                                i_reset,
    input  wire                                i_fetch_req,
    input  wire [boot_pkg::ROM_ADDR_WIDTH-1:0] i_fetch_line_idx,
    output logic                               o_fetch_busy,
    output logic                               o_fetch_valid,
    output boot_pkg::line_t                    o_fetch_line,
    output logic                               o_boot_done
);

    logic [boot_pkg::ROM_ADDR_WIDTH-1:0] rom_addr;
    boot_pkg::line_t rom_data;
    boot_pkg::biu_req_t boot_req;
    boot_pkg::biu_req_t host_req;
    boot_pkg::biu_req_t biu_req;
    boot_pkg::biu_rsp_t boot_rsp;
    boot_pkg::biu_rsp_t host_rsp;
    boot_pkg::biu_rsp_t biu_rsp;

    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    boot_pkg::wb_cti_e wb_cti;
    logic [boot_pkg::WB_ADDR_WIDTH-1:0] wb_addr;
    logic [boot_pkg::WB_DATA_WIDTH-1:0] wb_wdata;
    logic [boot_pkg::WB_DATA_WIDTH-1:0] wb_rdata;
    logic wb_ack;

    boot_rom u_boot_rom (
        .i_wb_clk(i_wb_clk),
        .i_addr(rom_addr),
        .o_data(rom_data)
    );

    boot_ctrl u_boot_ctrl (
        .i_wb_clk(i_wb_clk),
        .i_reset(i_reset),
        .i_rom_data(rom_data),
        .o_rom_addr(rom_addr),
        .o_req(boot_req),
        .i_rsp(boot_rsp),
        .o_boot_done(o_boot_done)
    );

    line_fetch u_line_fetch (
        .i_wb_clk(i_wb_clk),
        .i_reset(i_reset),
        .i_fetch_req(i_fetch_req),
        .i_fetch_line_idx(i_fetch_line_idx),
        .o_fetch_busy(o_fetch_busy),
        .o_fetch_valid(o_fetch_valid),
        .o_fetch_line(o_fetch_line),
        .o_req(host_req),
        .i_rsp(host_rsp)
    );

    bus_arbiter u_bus_arbiter (
        .i_wb_clk(i_wb_clk),
        .i_reset(i_reset),
        .i_req_boot(boot_req),
        .i_req_host(host_req),
        .o_rsp_boot(boot_rsp),
        .o_rsp_host(host_rsp),
        .o_req(biu_req),
        .i_rsp(biu_rsp)
    );

    biu_wb u_biu_wb (
        .i_wb_clk(i_wb_clk),
        .i_reset(i_reset),
        .i_req(biu_req),
        .o_rsp(biu_rsp),
        .i_wb_ack(wb_ack),
        .i_wb_data(wb_rdata),
        .o_wb_cyc(wb_cyc),
        .o_wb_stb(wb_stb),
        .o_wb_we(wb_we),
        .o_wb_cti(wb_cti),
        .o_wb_addr(wb_addr),
        .o_wb_data(wb_wdata)
    );

    wb_sram u_wb_sram (
        .i_wb_clk(i_wb_clk),
        .i_reset(i_reset),
        .i_wb_cyc(wb_cyc),
        .i_wb_stb(wb_stb),
        .i_wb_we(wb_we),
        .i_wb_cti(wb_cti),
        .i_wb_addr(wb_addr),
        .i_wb_data(wb_wdata),
        .o_wb_ack(wb_ack),
        .o_wb_data(wb_rdata)
    );

endmodule

`default_nettype wire

// ==== hw/wb_sram.sv ====
// ##########################################################
// Word-addressed Wishbone slave memory. Acks are registered and
// the next word is read ahead, so bursts run one beat a cycle.
// ##########################################################
`timescale 1ns/10ps
`default_nettype none

module wb_sram (
    input  wire                                i_wb_clk,
    input  wire                                i_reset,
    input  wire                                i_wb_cyc,
    input  wire                                i_wb_stb,
    input  wire                                i_wb_we,
    input  wire boot_pkg::wb_cti_e             i_wb_cti,
    input  wire [boot_pkg::WB_ADDR_WIDTH-1:0]  i_wb_addr,
    input  wire [boot_pkg::WB_DATA_WIDTH-1:0]  i_wb_data,
    output logic                               o_wb_ack,
    output logic [boot_pkg::WB_DATA_WIDTH-1:0] o_wb_data
);

    logic [boot_pkg::WB_DATA_WIDTH-1:0] mem [0:boot_pkg::SRAM_WORDS-1];
    logic [boot_pkg::SRAM_ADDR_WIDTH-1:0] word_idx;
    logic [boot_pkg::SRAM_ADDR_WIDTH-1:0] rd_idx;
    logic ack_r;
    logic burst_more;
    logic beat_done;

    assign word_idx = i_wb_addr[2 +: boot_pkg::SRAM_ADDR_WIDTH]; // Drop the byte offset.
    assign beat_done = i_wb_cyc & i_wb_stb & ack_r;
    assign burst_more = ack_r & (i_wb_cti == boot_pkg::CTI_INCR);

    // While an incrementing burst is acked the master is about to step to the next word.
    assign rd_idx = word_idx + (boot_pkg::SRAM_ADDR_WIDTH)'(burst_more);

    always_ff @(posedge i_wb_clk) begin
        if (i_reset) begin
            ack_r <= 1'b0;
        end else begin
            ack_r <= i_wb_cyc & i_wb_stb & ~(ack_r & ~burst_more);
        end
    end

    always_ff @(posedge i_wb_clk) begin
        if (beat_done && i_wb_we) begin
            mem[word_idx] <= i_wb_data;
        end
        o_wb_data <= mem[rd_idx];
    end

    assign o_wb_ack = ack_r;

endmodule

`default_nettype wire

// ==== hw/biu_wb.sv ====
// ##########################################################
// Bus interface unit. Turns one line request into a four-beat
// incrementing Wishbone burst and gathers or slices the line.
// ##########################################################
`timescale 1ns/10ps
`default_nettype none

module biu_wb (
    input  wire                                   i_wb_clk,
    input  wire                                   i_reset,
    input  wire boot_pkg::biu_req_t               i_req,
    output boot_pkg::biu_rsp_t                    o_rsp,
    input  wire                                   i_wb_ack,
    input  wire [boot_pkg::WB_DATA_WIDTH-1:0]     i_wb_data,
    output logic                                  o_wb_cyc,
    output logic                                  o_wb_stb,
    output logic                                  o_wb_we,
    output boot_pkg::wb_cti_e                     o_wb_cti,
    output logic [boot_pkg::WB_ADDR_WIDTH-1:0]    o_wb_addr,
    output logic [boot_pkg::WB_DATA_WIDTH-1:0]    o_wb_data
);

    localparam int RD_KEEP_WIDTH = boot_pkg::LINE_WIDTH - boot_pkg::WB_DATA_WIDTH;

    boot_pkg::biu_state_e state_r;
    logic [boot_pkg::BEAT_IDX_WIDTH-1:0] beat_r;
    logic [RD_KEEP_WIDTH-1:0] rd_line_r;
    logic burst;
    logic last_beat;

    assign burst = state_r == boot_pkg::BIU_BURST;
    assign last_beat = beat_r == (boot_pkg::BEAT_IDX_WIDTH)'(boot_pkg::BEATS_PER_LINE - 1);

    always_ff @(posedge i_wb_clk) begin
        if (i_reset) begin
            state_r <= boot_pkg::BIU_IDLE;
            beat_r <= '0;
        end else begin
            case (state_r)
                boot_pkg::BIU_IDLE: begin
                    beat_r <= '0;
                    if (i_req.en) begin
                        state_r <= boot_pkg::BIU_BURST;
                    end
                end
                boot_pkg::BIU_BURST: begin
                    if (i_wb_ack) begin
                        beat_r <= beat_r + 1'b1;
                        if (last_beat) begin
                            state_r <= boot_pkg::BIU_IDLE;
                        end
                    end
                end
                default: state_r <= boot_pkg::BIU_IDLE;
            endcase
        end
    end

    // Earlier read beats shift down so word 0 lands in the low bits.
    always_ff @(posedge i_wb_clk) begin
        if (burst && i_wb_ack) begin
            rd_line_r <= {i_wb_data, rd_line_r[RD_KEEP_WIDTH-1:boot_pkg::WB_DATA_WIDTH]};
        end
    end

    always_comb begin
        o_wb_cyc = burst;
        o_wb_stb = burst;
        o_wb_we = burst & i_req.write;
        if (!burst) begin
            o_wb_cti = boot_pkg::CTI_CLASSIC;
        end else if (last_beat) begin
            o_wb_cti = boot_pkg::CTI_EOB;
        end else begin
            o_wb_cti = boot_pkg::CTI_INCR;
        end
        o_wb_addr = i_req.addr
                  + (boot_pkg::WB_ADDR_WIDTH)'(beat_r) * (boot_pkg::WB_DATA_WIDTH / 8);
        o_wb_data = i_req.data[beat_r * boot_pkg::WB_DATA_WIDTH +: boot_pkg::WB_DATA_WIDTH];

        o_rsp.done = burst & i_wb_ack & last_beat;
        o_rsp.data = {i_wb_data, rd_line_r}; // Last word comes straight off the bus.
    end

endmodule

`default_nettype wire

// ==== hw/bus_arbiter.sv ====
// ##########################################################
// Round-robin arbiter between the boot sequencer and the host
// port. A grant lasts for one whole line transfer.
// ##########################################################
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter (
    input  wire                     i_wb_clk,
    input  wire                     i_reset,
    input  wire boot_pkg::biu_req_t i_req_boot,
    input  wire boot_pkg::biu_req_t i_req_host,
    output boot_pkg::biu_rsp_t      o_rsp_boot,
    output boot_pkg::biu_rsp_t      o_rsp_host,
    output boot_pkg::biu_req_t      o_req,
    input  wire boot_pkg::biu_rsp_t i_rsp
);

    logic busy_r;
    logic owner_host_r;
    logic last_host_r;
    logic pick_host;
    boot_pkg::biu_req_t sel_req;

    // Favour whichever side was not served last.
    assign pick_host = last_host_r ? ~i_req_boot.en : i_req_host.en;

    always_ff @(posedge i_wb_clk) begin
        if (i_reset) begin
            busy_r <= 1'b0;
            owner_host_r <= 1'b0;
            last_host_r <= 1'b1;
        end else if (!busy_r) begin
            if (i_req_boot.en || i_req_host.en) begin
                busy_r <= 1'b1;
                owner_host_r <= pick_host;
            end
        end else if (i_rsp.done) begin
            busy_r <= 1'b0;
            last_host_r <= owner_host_r;
        end
    end

    assign sel_req = owner_host_r ? i_req_host : i_req_boot;

    always_comb begin
        o_req = sel_req;
        o_req.en = busy_r & sel_req.en;

        o_rsp_boot = i_rsp;
        o_rsp_boot.done = i_rsp.done & busy_r & ~owner_host_r;
        o_rsp_host = i_rsp;
        o_rsp_host.done = i_rsp.done & busy_r & owner_host_r;
    end

endmodule

`default_nettype wire

// ==== hw/line_fetch.sv ====
// ##########################################################
// Host fetch port. A strobe while idle starts one line read
// through the BIU; the line returns with a one-cycle valid.
// ##########################################################
`timescale 1ns/10ps
`default_nettype none

module line_fetch (
    input  wire                                i_wb_clk,
    input  wire                                i_reset,
    input  wire                                i_fetch_req,
    input  wire [boot_pkg::ROM_ADDR_WIDTH-1:0] i_fetch_line_idx,
    output logic                               o_fetch_busy,
    output logic                               o_fetch_valid,
    output boot_pkg::line_t                    o_fetch_line,
    output boot_pkg::biu_req_t                 o_req,
    input  wire boot_pkg::biu_rsp_t            i_rsp
);

    logic pending_r;
    logic valid_r;
    logic [boot_pkg::ROM_ADDR_WIDTH-1:0] idx_r;
    boot_pkg::line_t line_r;
    logic accept;

    assign accept = i_fetch_req & ~pending_r; // Strobes during a pending fetch are dropped.

    always_ff @(posedge i_wb_clk) begin
        if (i_reset) begin
            pending_r <= 1'b0;
            valid_r <= 1'b0;
        end else begin
            valid_r <= i_rsp.done;
            if (accept) begin
                pending_r <= 1'b1;
            end else if (i_rsp.done) begin
                pending_r <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_wb_clk) begin
        if (accept) begin
            idx_r <= i_fetch_line_idx;
        end
        if (i_rsp.done) begin
            line_r <= i_rsp.data;
        end
    end

    assign o_fetch_busy = pending_r;
    assign o_fetch_valid = valid_r;
    assign o_fetch_line = line_r;

    always_comb begin
        o_req.en = pending_r;
        o_req.write = 1'b0;
        o_req.addr = (boot_pkg::WB_ADDR_WIDTH)'(idx_r) * boot_pkg::LINE_BYTES;
        o_req.data = '0;
    end

endmodule

`default_nettype wire

// ==== hw/boot_ctrl.sv ====
// ##########################################################
// Power-on sequencer. Copies every ROM line into memory with
// one BIU line write each and then holds o_boot_done high.
// ##########################################################
`timescale 1ns/10ps
`default_nettype none

module boot_ctrl (
    input  wire                                 i_wb_clk,
    input  wire                                 i_reset,
    input  wire boot_pkg::line_t                i_rom_data,
    output logic [boot_pkg::ROM_ADDR_WIDTH-1:0] o_rom_addr,
    output boot_pkg::biu_req_t                  o_req,
    input  wire boot_pkg::biu_rsp_t             i_rsp,
    output logic                                o_boot_done
);

    boot_pkg::boot_state_e state_r;
    boot_pkg::boot_state_e state_next;
    logic [boot_pkg::ROM_ADDR_WIDTH-1:0] rom_addr_r;
    logic [boot_pkg::ROM_ADDR_WIDTH-1:0] rom_addr_next;
    logic en_r;
    logic en_next;
    boot_pkg::line_t line_r;
    logic last_line;

    assign last_line = rom_addr_r == (boot_pkg::ROM_ADDR_WIDTH)'(boot_pkg::ROM_LINES - 1);

    always_comb begin
        state_next = state_r;
        en_next = 1'b0;
        rom_addr_next = rom_addr_r;
        case (state_r)
            boot_pkg::BOOT_RESET: begin
                state_next = boot_pkg::BOOT_BUSY;
                rom_addr_next = '0;
            end
            boot_pkg::BOOT_BUSY: begin
                en_next = ~i_rsp.done; // Drops for one cycle while the next line loads.
                rom_addr_next = rom_addr_r + (boot_pkg::ROM_ADDR_WIDTH)'(i_rsp.done);
                if (i_rsp.done && last_line) begin
                    state_next = boot_pkg::BOOT_DONE;
                end
            end
            default: state_next = boot_pkg::BOOT_DONE;
        endcase
    end

    always_ff @(posedge i_wb_clk) begin
        if (i_reset) begin
            state_r <= boot_pkg::BOOT_RESET;
            rom_addr_r <= '0;
            en_r <= 1'b0;
        end else begin
            state_r <= state_next;
            rom_addr_r <= rom_addr_next;
            en_r <= en_next;
        end
    end

    always_ff @(posedge i_wb_clk) begin
        line_r <= i_rom_data;
    end

    // The ROM is addressed one step ahead so its line is registered before en rises.
    assign o_rom_addr = rom_addr_next;
    assign o_boot_done = state_r == boot_pkg::BOOT_DONE;

    always_comb begin
        o_req.en = en_r;
        o_req.write = 1'b1;
        o_req.addr = (boot_pkg::WB_ADDR_WIDTH)'(rom_addr_r) * boot_pkg::LINE_BYTES;
        o_req.data = line_r;
    end

endmodule

`default_nettype wire

// ==== hw/boot_rom.sv ====
// ##########################################################
// Line-wide boot ROM holding the power-on image.
// The image is loaded at elaboration; reads take one cycle.
// ##########################################################
`timescale 1ns/10ps
`default_nettype none

module boot_rom (
    input  wire                                i_wb_clk,
    input  wire [boot_pkg::ROM_ADDR_WIDTH-1:0] i_addr,
    output boot_pkg::line_t                    o_data
);

    boot_pkg::line_t rom [0:boot_pkg::ROM_LINES-1];

    initial begin
        $readmemh("tests/boot_image.hex", rom);
    end

    always_ff @(posedge i_wb_clk) begin
        o_data <= rom[i_addr];
    end

endmodule

`default_nettype wire

// ==== hw/boot_pkg.sv ====
// ##########################################################
// Shared sizes, BIU request/response structs and the FSM and
// Wishbone cycle-type encodings for the boot subsystem.
// ##########################################################
`default_nettype none

package boot_pkg;

    localparam int LINE_BYTES     = 16;
    localparam int LINE_WIDTH     = LINE_BYTES * 8;
    localparam int WB_DATA_WIDTH  = 32;
    localparam int WB_ADDR_WIDTH  = 32;
    localparam int BEATS_PER_LINE = LINE_WIDTH / WB_DATA_WIDTH;
    localparam int BEAT_IDX_WIDTH = 2;
    localparam int ROM_LINES      = 8;
    localparam int ROM_ADDR_WIDTH = 3;
    localparam int SRAM_WORDS     = ROM_LINES * BEATS_PER_LINE;
    localparam int SRAM_ADDR_WIDTH = $clog2(SRAM_WORDS);

    // Word 0 of a line sits in the low 32 bits.
    typedef logic [LINE_WIDTH-1:0] line_t;

    typedef struct packed {
        logic                     en;     // Held until done is seen.
        logic                     write;
        logic [WB_ADDR_WIDTH-1:0] addr;   // Byte address of the line.
        line_t                    data;
    } biu_req_t;

    typedef struct packed {
        logic  done;
        line_t data;
    } biu_rsp_t;

    typedef enum logic [2:0] {
        CTI_CLASSIC = 3'b000,
        CTI_INCR    = 3'b010,
        CTI_EOB     = 3'b111
    } wb_cti_e;

    typedef enum logic [1:0] {
        BOOT_RESET = 2'b00,
        BOOT_BUSY  = 2'b01,
        BOOT_DONE  = 2'b10
    } boot_state_e;

    typedef enum logic {
        BIU_IDLE  = 1'b0,
        BIU_BURST = 1'b1
    } biu_state_e;

endpackage

`default_nettype wire
